// ==== verilog/uart_params.svh ====
`ifndef UART_PARAMS_SVH
`define UART_PARAMS_SVH

// Bit-period counter width, 16 also works
`define UART_CNT_W   32

`define UART_DATA_W  8

// Shorter runs are treated as glitches
`define UART_MIN_RUN 2

`endif

// ==== verilog/uart_pkg.sv ====
package uart_pkg;

   `include "uart_params.svh"

   // Clock cycles, used for bit periods and bit timers
   typedef logic [`UART_CNT_W-1:0] cnt_t;

   // One character on the line
   typedef logic [`UART_DATA_W-1:0] data_t;

   // Receive FSM
   typedef enum logic [3:0] {
      RX_IDLE  = 4'h0,  // Line idle, looking for a start edge
      RX_START = 4'h1,  // Moving to mid-bit of the start bit
      RX_DATA  = 4'h2,  // Sampling data bits
      RX_WAIT  = 4'h3   // Waiting for the line to go high
   } rx_state_t;

   // Transmit FSM
   typedef enum logic [3:0] {
      TX_IDLE  = 4'h0,  // Ready for a byte
      TX_DATA  = 4'h1,  // Start bit and data bits
      TX_STOP  = 4'h2,  // Last data bit, then the stop bit
      TX_GUARD = 4'h3   // Line held high one more bit
   } tx_state_t;

   // Bit index of the last data bit
   localparam logic [2:0] LAST_BIT = 3'(`UART_DATA_W - 1);

endpackage

// ==== verilog/baud_detect.sv ====
`timescale 1ns/1ps
`include "uart_params.svh"

module baud_detect (
   input  logic           i_clk,
   input  logic           i_nrst,
   input  logic           i_rx,
   output uart_pkg::cnt_t o_baud_period,
   output logic           o_resync
);
   import uart_pkg::*;

   logic rx_meta;
   logic rx_sync;
   cnt_t timer;
   logic run_end;
   logic shorter;

   // A run ends when the two synchronizer stages disagree
   assign run_end = (rx_meta != rx_sync);

   assign shorter = (timer < o_baud_period) &&
                    (timer >= cnt_t'(`UART_MIN_RUN));

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         rx_meta <= 1'b1;   // Line idles high
         rx_sync <= 1'b1;
      end else begin
         rx_meta <= i_rx;
         rx_sync <= rx_meta;
      end
   end

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         timer <= '0;
      end else if (run_end) begin
         timer <= '0;
      end else if (timer != '1) begin   // Saturate on a long idle line
         timer <= timer + 1'b1;
      end
   end

   // Keep the shortest run seen so far
   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         o_baud_period <= '1;
         o_resync      <= 1'b0;
      end else begin
         o_resync <= 1'b0;
         if (run_end && shorter) begin
            o_baud_period <= timer;
            o_resync      <= 1'b1;   // Engines restart their bit timers
         end
      end
   end

   // Period can only shrink until the next reset
   a_period_monotonic : assert property (
      @(posedge i_clk) disable iff (!i_nrst)
      o_baud_period <= $past(o_baud_period)
   );

endmodule

// ==== verilog/uart_rx.sv ====
`timescale 1ns/1ps
`include "uart_params.svh"

module uart_rx (
   input  logic            i_clk,
   input  logic            i_nrst,
   input  logic            i_rx,
   input  uart_pkg::cnt_t  i_baud_period,
   input  logic            i_resync,
   output logic            o_busy,
   output logic            o_received,
   output uart_pkg::data_t o_data
);
   import uart_pkg::*;

   rx_state_t  state;
   cnt_t       count;
   logic [2:0] bit_idx;
   logic       start_mid;
   logic       bit_done;

   assign start_mid = (state == RX_START) && (count == (i_baud_period >> 1));
   assign bit_done  = (state == RX_DATA) && (count == i_baud_period);

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         state      <= RX_IDLE;
         count      <= '0;
         bit_idx    <= '0;
         o_busy     <= 1'b0;
         o_received <= 1'b0;
      end else begin
         o_received <= 1'b0;
         count      <= i_resync ? '0 : count + 1'b1;

         case (state)
            RX_IDLE: begin
               count   <= '0;
               bit_idx <= '0;
               if (!i_rx) begin   // Start edge
                  state  <= RX_START;
                  o_busy <= 1'b1;
               end
            end

            RX_START: begin
               if (start_mid) begin
                  state <= RX_DATA;
                  count <= '0;
               end
            end

            RX_DATA: begin
               if (bit_done) begin
                  count   <= '0;
                  bit_idx <= bit_idx + 1'b1;
                  if (bit_idx == LAST_BIT) begin
                     state      <= RX_WAIT;
                     o_received <= 1'b1;   // Same edge that takes the last bit
                  end
               end
            end

            RX_WAIT: begin
               if (i_rx) begin
                  state  <= RX_IDLE;
                  o_busy <= 1'b0;
               end
            end

            default: state <= RX_IDLE;
         endcase
      end
   end

   // LSB first, so new bits enter at the top
   always_ff @(posedge i_clk) begin
      if (bit_done) begin
         o_data <= {i_rx, o_data[`UART_DATA_W-1:1]};
      end
   end

   a_received_pulse : assert property (
      @(posedge i_clk) disable iff (!i_nrst)
      o_received |=> !o_received
   );

endmodule

// ==== verilog/uart_tx.sv ====
`timescale 1ns/1ps

module uart_tx (
   input  logic            i_clk,
   input  logic            i_nrst,
   input  logic            i_transmit,
   input  uart_pkg::data_t i_data,
   input  uart_pkg::cnt_t  i_baud_period,
   input  logic            i_resync,
   output logic            o_busy,
   output logic            o_tx
);
   import uart_pkg::*;

   tx_state_t  state;
   cnt_t       count;
   logic [2:0] bit_idx;
   data_t      shift;
   logic       bit_done;
   logic       load_byte;
   logic       shift_bit;

   assign bit_done  = (count == i_baud_period);
   assign load_byte = (state == TX_IDLE) && i_transmit;
   assign shift_bit = (state == TX_DATA) && bit_done;

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         state   <= TX_IDLE;
         count   <= '0;
         bit_idx <= '0;
         o_busy  <= 1'b0;
         o_tx    <= 1'b1;
      end else begin
         count <= i_resync ? '0 : count + 1'b1;

         case (state)
            TX_IDLE: begin
               count   <= '0;
               bit_idx <= '0;
               if (i_transmit) begin
                  state  <= TX_DATA;
                  o_busy <= 1'b1;
                  o_tx   <= 1'b0;   // Start bit
               end
            end

            TX_DATA: begin
               if (bit_done) begin
                  o_tx    <= shift[0];
                  count   <= '0;
                  bit_idx <= bit_idx + 1'b1;   // Wraps to 0 after the last bit
                  if (bit_idx == LAST_BIT)
                     state <= TX_STOP;
               end
            end

            // First expiry ends the last data bit, second ends the stop bit
            TX_STOP: begin
               if (bit_done) begin
                  o_tx    <= 1'b1;
                  count   <= '0;
                  bit_idx <= bit_idx + 1'b1;
                  if (bit_idx[0])
                     state <= TX_GUARD;
               end
            end

            TX_GUARD: begin
               if (bit_done) begin
                  state  <= TX_IDLE;
                  o_busy <= 1'b0;
               end
            end

            default: state <= TX_IDLE;
         endcase
      end
   end

   always_ff @(posedge i_clk) begin
      if (load_byte)
         shift <= i_data;
      else if (shift_bit)
         shift <= shift >> 1;
   end

   a_idle_line_high : assert property (
      @(posedge i_clk) disable iff (!i_nrst)
      !o_busy |-> o_tx
   );

endmodule

// ==== verilog/uart_autobaud.sv ====
`timescale 1ns/1ps

module uart_autobaud (
   input  logic            i_clk,
   input  logic            i_nrst,
   input  logic            i_transmit,   // Sampled only while not busy
   input  uart_pkg::data_t i_data_tx,
   input  logic            i_rx,
   output logic            o_busy_tx,
   output logic            o_busy_rx,
   output logic            o_received,   // One-cycle strobe
   output uart_pkg::data_t o_data_rx,
   output logic            o_tx
);
   import uart_pkg::*;

   cnt_t baud_period;
   logic baud_resync;

   // Both engines share the measured period
   baud_detect u_baud_detect (
      .i_clk         (i_clk),
      .i_nrst        (i_nrst),
      .i_rx          (i_rx),
      .o_baud_period (baud_period),
      .o_resync      (baud_resync)
   );

   uart_rx u_uart_rx (
      .i_clk         (i_clk),
      .i_nrst        (i_nrst),
      .i_rx          (i_rx),
      .i_baud_period (baud_period),
      .i_resync      (baud_resync),
      .o_busy        (o_busy_rx),
      .o_received    (o_received),
      .o_data        (o_data_rx)
   );

   uart_tx u_uart_tx (
      .i_clk         (i_clk),
      .i_nrst        (i_nrst),
      .i_transmit    (i_transmit),
      .i_data        (i_data_tx),
      .i_baud_period (baud_period),
      .i_resync      (baud_resync),
      .o_busy        (o_busy_tx),
      .o_tx          (o_tx)
   );

endmodule

// ==== tb/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen (
   output logic o_clk,
   output logic o_nrst
);

   localparam int HALF_PERIOD_NS = 10;   // 20 ns clock
   localparam int RESET_CYCLES   = 5;

   initial begin
      o_clk = 1'b0;
      forever #(HALF_PERIOD_NS) o_clk = ~o_clk;
   end

   // Active-low reset, released on a rising edge
   initial begin
      o_nrst = 1'b0;
      repeat (RESET_CYCLES) @(posedge o_clk);
      o_nrst <= 1'b1;
   end

endmodule

// ==== tb/tb_uart_autobaud.sv ====
`timescale 1ns/1ps

module tb_uart_autobaud;

   localparam int CLK_PERIOD_NS = 20;
   localparam int NUM_ROWS      = 5;
   localparam int MAX_WIDTH     = 24;
   localparam int BITS_PER_ROW  = 24;
   localparam int WATCHDOG_NS   = NUM_ROWS * BITS_PER_ROW * MAX_WIDTH * CLK_PERIOD_NS * 2;

   localparam logic [31:0] LFSR_SEED  = 32'h5f8e60e8;
   localparam logic [31:0] LFSR_TAPS  = 32'h80200003;
   localparam logic [7:0]  TRAIN_BYTE = 8'h55;   // Every run is one bit long

   typedef struct packed {
      logic [7:0] width;     // Bit time in clocks
      logic [7:0] rx_byte;   // Sent on i_rx
      logic [7:0] tx_byte;   // Given to the transmitter
   } row_t;

   // Wide to narrow, the measured period never grows
   localparam row_t ROWS [NUM_ROWS] = '{
      '{8'd24, 8'hA3, 8'h3C},
      '{8'd24, 8'h0F, 8'h80},
      '{8'd16, 8'hC8, 8'h00},
      '{8'd16, 8'h71, 8'hFF},
      '{8'd12, 8'hE6, 8'h5A}
   };

   logic       clk;
   logic       nrst;
   logic       transmit;
   logic [7:0] data_tx;
   logic       rx_line;
   logic       busy_tx;
   logic       busy_rx;
   logic       received;
   logic [7:0] data_rx;
   logic       tx_line;

   logic [31:0] lfsr_state = LFSR_SEED;
   int          rx_pulses  = 0;
   logic [7:0]  rx_value;
   logic        tx_samples [0:10*MAX_WIDTH-1];   // One o_tx sample per clock

   tb_clock_gen u_clock_gen (
      .o_clk  (clk),
      .o_nrst (nrst)
   );

   uart_autobaud dut (
      .i_clk      (clk),
      .i_nrst     (nrst),
      .i_transmit (transmit),
      .i_data_tx  (data_tx),
      .i_rx       (rx_line),
      .o_busy_tx  (busy_tx),
      .o_busy_rx  (busy_rx),
      .o_received (received),
      .o_data_rx  (data_rx),
      .o_tx       (tx_line)
   );

   task automatic check_value(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
      if (actual !== expected) begin
         $display("MISMATCH %s: got 0x%0h, expected 0x%0h at %0t",
                  name, actual, expected, $time);
         $display("Test failures found");
         $fatal(1, "Stopped at the first error");
      end
   endtask

   // Galois form, shifts right
   function automatic logic [31:0] lfsr_next(input logic [31:0] state);
      return (state >> 1) ^ (state[0] ? LFSR_TAPS : 32'h0);
   endfunction

   task automatic random_bits(input int count, output int value);
      int i;
      value = 0;
      for (i = 0; i < count; i++) begin
         value      = (value << 1) | int'(lfsr_state[0]);
         lfsr_state = lfsr_next(lfsr_state);
      end
   endtask

   // Start bit plus the zero bits right after it
   function automatic int leading_low_bits(input logic [7:0] value);
      int   n;
      int   i;
      logic seen_one;
      n        = 1;
      seen_one = 1'b0;
      for (i = 0; i < 8; i++) begin
         if (value[i])
            seen_one = 1'b1;
         else if (!seen_one)
            n++;
      end
      return n;
   endfunction

   task automatic idle_gap(input int cycles);
      repeat (cycles) @(posedge clk);
   endtask

   task automatic send_frame(input logic [7:0] value, input int width,
                             input logic check_busy);
      logic [9:0] frame;
      int         b;
      int         c;
      frame = {1'b1, value, 1'b0};
      for (b = 0; b < 10; b++) begin
         rx_line <= frame[b];
         for (c = 0; c < width; c++) begin
            @(negedge clk);
            if (check_busy && b == 0 && c == width / 2)
               check_value("o_busy_rx", 32'(busy_rx), 32'h1);   // Mid start bit
            @(posedge clk);
         end
      end
   endtask

   task automatic wait_rx_idle();
      @(negedge clk);
      while (busy_rx)
         @(negedge clk);
      @(posedge clk);
   endtask

   task automatic capture_tx_frame(input int width, output int busy_cycles);
      int s;
      busy_cycles = 0;
      @(negedge clk);
      while (tx_line)
         @(negedge clk);
      for (s = 0; s < 10 * width; s++) begin
         tx_samples[s] = tx_line;
         if (busy_tx)
            busy_cycles++;
         @(negedge clk);
      end
      while (busy_tx) begin   // Guard bit
         busy_cycles++;
         @(negedge clk);
      end
   endtask

   task automatic transmit_and_check(input logic [7:0] value, input int width);
      int         busy_cycles;
      int         low_run;
      int         expected_run;
      int         i;
      logic [7:0] decoded;
      transmit <= 1'b1;
      data_tx  <= value;
      @(posedge clk);
      transmit <= 1'b0;
      fork
         capture_tx_frame(width, busy_cycles);
         begin
            // Extra request while busy
            repeat (4 * width) @(posedge clk);
            transmit <= 1'b1;
            data_tx  <= ~value;
            @(posedge clk);
            transmit <= 1'b0;
         end
      join
      check_value("o_tx start bit", 32'(tx_samples[width / 2]), 32'h0);
      for (i = 0; i < 8; i++)
         decoded[i] = tx_samples[(i + 1) * width + width / 2];
      check_value("o_tx data", 32'(decoded), 32'(value));
      check_value("o_tx stop bit", 32'(tx_samples[9 * width + width / 2]), 32'h1);
      low_run = 0;
      while (low_run < 10 * width && !tx_samples[low_run])
         low_run++;
      expected_run = leading_low_bits(value) * width;
      if (low_run >= expected_run - 1 && low_run <= expected_run + 1)
         low_run = expected_run;   // One clock of slack
      check_value("o_tx low run", 32'(low_run), 32'(expected_run));
      if (busy_cycles >= 11 * width)
         busy_cycles = 11 * width;
      check_value("o_busy_tx cycles", 32'(busy_cycles), 32'(11 * width));
      for (i = 0; i < 2 * width; i++) begin
         check_value("o_tx", 32'(tx_line), 32'h1);
         check_value("o_busy_tx", 32'(busy_tx), 32'h0);
         @(negedge clk);
      end
      @(posedge clk);
   endtask

   initial begin : rx_monitor
      forever begin
         @(negedge clk);
         if (received) begin
            rx_pulses = rx_pulses + 1;
            rx_value  = data_rx;
         end
      end
   end

   initial begin : watchdog
      #(WATCHDOG_NS);
      $display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
      $display("Test failures found");
      $fatal(1, "Watchdog expired");
   end

   initial begin : main
      int r;
      int w;
      int gap;
      int pulses_before;
      transmit = 1'b0;
      data_tx  = 8'h00;
      rx_line  = 1'b1;
      wait (nrst === 1'b1);
      @(posedge clk);
      @(negedge clk);
      check_value("o_tx", 32'(tx_line), 32'h1);
      check_value("o_busy_tx", 32'(busy_tx), 32'h0);
      check_value("o_busy_rx", 32'(busy_rx), 32'h0);
      check_value("o_received", 32'(received), 32'h0);
      @(posedge clk);

      for (r = 0; r < NUM_ROWS; r++) begin
         w = int'(ROWS[r].width);
         random_bits(5, gap);
         idle_gap(2 * w + gap);
         send_frame(TRAIN_BYTE, w, 1'b0);   // Receiver output ignored here
         wait_rx_idle();
         idle_gap(w);
         pulses_before = rx_pulses;
         send_frame(ROWS[r].rx_byte, w, 1'b1);
         @(negedge clk);
         check_value("o_busy_rx", 32'(busy_rx), 32'h0);
         check_value("o_received pulses", 32'(rx_pulses - pulses_before), 32'h1);
         check_value("o_data_rx", 32'(rx_value), 32'(ROWS[r].rx_byte));
         @(posedge clk);
         transmit_and_check(ROWS[r].tx_byte, w);
      end

      $display("All tests passed!");
      $finish;
   end

endmodule

// ==== verilog.f ====
+incdir+verilog
verilog/uart_pkg.sv
verilog/baud_detect.sv
verilog/uart_rx.sv
verilog/uart_tx.sv
verilog/uart_autobaud.sv
tb/tb_clock_gen.sv
tb/tb_uart_autobaud.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_uart_autobaud
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SOURCES := $(shell grep -v '^+' $(FILELIST)) $(wildcard verilog/*.svh)
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM_BIN)

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

# The exit status of the simulator is the test result
run: $(SIM_BIN)
	./$(SIM_BIN)

clean:
	rm -rf $(BUILD_DIR)
